// ==== source/mipsPkg.sv ====
`default_nettype none

package mipsPkg;

	typedef logic [31:0] wordT;
	typedef logic [4:0]  regIndexT;
	typedef logic [4:0]  shamtT;
	typedef logic [5:0]  opcodeT;
	typedef logic [5:0]  functT;
	typedef logic [15:0] immT;

	typedef enum logic [3:0] {
		aluAnd  = 4'd0,
		aluOr   = 4'd1,
		aluNor  = 4'd2,
		aluXor  = 4'd3,
		aluSlt  = 4'd4,
		aluSltu = 4'd5,
		aluAdd  = 4'd6,
		aluSub  = 4'd7,
		aluSll  = 4'd8,
		aluSrl  = 4'd9,
		aluSra  = 4'd10,
		aluClo  = 4'd11,
		aluClz  = 4'd12
	} aluOpT;

	localparam opcodeT opSpecial  = 6'h00;
	localparam opcodeT opSpecial2 = 6'h1C;
	localparam opcodeT opAddi     = 6'h08;
	localparam opcodeT opAddiu    = 6'h09;
	localparam opcodeT opSlti     = 6'h0A;
	localparam opcodeT opSltiu    = 6'h0B;
	localparam opcodeT opAndi     = 6'h0C;
	localparam opcodeT opOri      = 6'h0D;
	localparam opcodeT opXori     = 6'h0E;
	localparam opcodeT opLui      = 6'h0F;

	localparam functT fnSll  = 6'h00;
	localparam functT fnSrl  = 6'h02;
	localparam functT fnSra  = 6'h03;
	localparam functT fnSllv = 6'h04;
	localparam functT fnSrlv = 6'h06;
	localparam functT fnSrav = 6'h07;
	localparam functT fnAdd  = 6'h20;
	localparam functT fnAddu = 6'h21;
	localparam functT fnSub  = 6'h22;
	localparam functT fnSubu = 6'h23;
	localparam functT fnAnd  = 6'h24;
	localparam functT fnOr   = 6'h25;
	localparam functT fnXor  = 6'h26;
	localparam functT fnNor  = 6'h27;
	localparam functT fnSlt  = 6'h2A;
	localparam functT fnSltu = 6'h2B;
	localparam functT fnClz  = 6'h20; // SPECIAL2 space
	localparam functT fnClo  = 6'h21;

	typedef struct packed {
		opcodeT   opcode;
		functT    funct;
		shamtT    shamt;
		wordT     rsValue;
		wordT     rtValue;
		immT      immediate;
		regIndexT destReg;
	} executeRequestT;

	typedef struct packed {
		aluOpT aluOperation;
		logic  useImmediate;
		logic  zeroExtend;
		logic  shiftByShamt;
		logic  loadUpper;
		logic  trapOnOverflow;
		logic  legal;
	} aluDecodeT;

	typedef struct packed {
		wordT     result;
		regIndexT destReg;
		logic     regWrite;
		logic     overflowTrap;
		logic     illegal;
	} executeResultT;

endpackage

`default_nettype wire

// ==== source/AluControl.sv ====
`default_nettype none

module AluControl (
	input  mipsPkg::opcodeT    opcode,
	input  mipsPkg::functT     funct,
	output mipsPkg::aluDecodeT decode
);

	always_comb begin
		decode = '{aluOperation: mipsPkg::aluAnd, default: 1'b0};
		decode.legal = 1'b1;
		case (opcode)
			mipsPkg::opSpecial: begin
				case (funct)
					mipsPkg::fnAnd:  decode.aluOperation = mipsPkg::aluAnd;
					mipsPkg::fnOr:   decode.aluOperation = mipsPkg::aluOr;
					mipsPkg::fnNor:  decode.aluOperation = mipsPkg::aluNor;
					mipsPkg::fnXor:  decode.aluOperation = mipsPkg::aluXor;
					mipsPkg::fnSlt:  decode.aluOperation = mipsPkg::aluSlt;
					mipsPkg::fnSltu: decode.aluOperation = mipsPkg::aluSltu;
					mipsPkg::fnAddu: decode.aluOperation = mipsPkg::aluAdd;
					mipsPkg::fnSubu: decode.aluOperation = mipsPkg::aluSub;
					mipsPkg::fnSllv: decode.aluOperation = mipsPkg::aluSll;
					mipsPkg::fnSrlv: decode.aluOperation = mipsPkg::aluSrl;
					mipsPkg::fnSrav: decode.aluOperation = mipsPkg::aluSra;
					mipsPkg::fnAdd: begin
						decode.aluOperation   = mipsPkg::aluAdd;
						decode.trapOnOverflow = 1'b1;
					end
					mipsPkg::fnSub: begin
						decode.aluOperation   = mipsPkg::aluSub;
						decode.trapOnOverflow = 1'b1;
					end
					mipsPkg::fnSll: begin
						decode.aluOperation = mipsPkg::aluSll;
						decode.shiftByShamt = 1'b1; // amount from shamt field
					end
					mipsPkg::fnSrl: begin
						decode.aluOperation = mipsPkg::aluSrl;
						decode.shiftByShamt = 1'b1;
					end
					mipsPkg::fnSra: begin
						decode.aluOperation = mipsPkg::aluSra;
						decode.shiftByShamt = 1'b1;
					end
					default: decode.legal = 1'b0;
				endcase
			end
			mipsPkg::opSpecial2: begin
				case (funct)
					mipsPkg::fnClz: decode.aluOperation = mipsPkg::aluClz;
					mipsPkg::fnClo: decode.aluOperation = mipsPkg::aluClo;
					default:        decode.legal = 1'b0;
				endcase
			end
			mipsPkg::opAddi: begin
				decode.aluOperation   = mipsPkg::aluAdd;
				decode.useImmediate   = 1'b1;
				decode.trapOnOverflow = 1'b1;
			end
			mipsPkg::opAddiu: begin
				decode.aluOperation = mipsPkg::aluAdd;
				decode.useImmediate = 1'b1;
			end
			mipsPkg::opSlti: begin
				decode.aluOperation = mipsPkg::aluSlt;
				decode.useImmediate = 1'b1;
			end
			mipsPkg::opSltiu: begin
				decode.aluOperation = mipsPkg::aluSltu; // imm still sign extended
				decode.useImmediate = 1'b1;
			end
			mipsPkg::opAndi, mipsPkg::opOri, mipsPkg::opXori: begin
				decode.aluOperation = (opcode == mipsPkg::opAndi) ? mipsPkg::aluAnd :
					(opcode == mipsPkg::opOri) ? mipsPkg::aluOr : mipsPkg::aluXor;
				decode.useImmediate = 1'b1;
				decode.zeroExtend   = 1'b1;
			end
			mipsPkg::opLui: begin
				decode.aluOperation = mipsPkg::aluSll; // imm << 16
				decode.useImmediate = 1'b1;
				decode.zeroExtend   = 1'b1;
				decode.loadUpper    = 1'b1;
			end
			default: decode.legal = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// ==== source/OperandSelect.sv ====
`default_nettype none

module OperandSelect (
	input  mipsPkg::executeRequestT request,
	input  mipsPkg::aluDecodeT      decode,
	output mipsPkg::wordT           aluInputA,
	output mipsPkg::wordT           aluInputB
);

	mipsPkg::wordT immExtended;

	assign immExtended = decode.zeroExtend ?
		{16'b0, request.immediate} :
		{{16{request.immediate[15]}}, request.immediate};

	always_comb begin
		if (decode.loadUpper) begin
			aluInputA = 32'd16; // fixed shift for lui
			aluInputB = immExtended;
		end else if (decode.shiftByShamt) begin
			aluInputA = {27'b0, request.shamt};
			aluInputB = request.rtValue;
		end else if (decode.useImmediate) begin
			aluInputA = request.rsValue;
			aluInputB = immExtended;
		end else begin
			// register forms, variable shifts included
			aluInputA = request.rsValue;
			aluInputB = request.rtValue;
		end
	end

endmodule

`default_nettype wire

// ==== source/LeadingCount.sv ====
`default_nettype none

module LeadingCount (
	input  mipsPkg::wordT value,
	input  logic          countOnes,
	output logic [5:0]    count
);

	mipsPkg::wordT scanValue;

	assign scanValue = countOnes ? ~value : value;

	// priority scan, msb first
	always_comb begin
		logic found;
		found = 1'b0;
		count = 6'd32; // nothing set
		for (int i = 31; i >= 0; i--) begin
			if (!found && scanValue[i]) begin
				found = 1'b1;
				count = 6'(31 - i);
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/ArithmeticLogicalUnit.sv ====
`default_nettype none

module ArithmeticLogicalUnit (
	input  mipsPkg::wordT  aluInputA,
	input  mipsPkg::wordT  aluInputB,
	input  mipsPkg::aluOpT aluOperation,
	output mipsPkg::wordT  aluOutput,
	output logic           aluOverFlow
);

	logic [5:0] leadingCount;
	logic [4:0] shiftAmount;

	assign shiftAmount = aluInputA[4:0];

	LeadingCount leadingCounter (
		.value     (aluInputA),
		.countOnes (aluOperation == mipsPkg::aluClo),
		.count     (leadingCount)
	);

	always_comb begin
		case (aluOperation)
			mipsPkg::aluAnd:  aluOutput = aluInputA & aluInputB;
			mipsPkg::aluOr:   aluOutput = aluInputA | aluInputB;
			mipsPkg::aluNor:  aluOutput = ~(aluInputA | aluInputB);
			mipsPkg::aluXor:  aluOutput = aluInputA ^ aluInputB;
			mipsPkg::aluSlt:  aluOutput = {31'b0, $signed(aluInputA) < $signed(aluInputB)};
			mipsPkg::aluSltu: aluOutput = {31'b0, aluInputA < aluInputB};
			mipsPkg::aluAdd:  aluOutput = aluInputA + aluInputB;
			mipsPkg::aluSub:  aluOutput = aluInputA - aluInputB;
			mipsPkg::aluSll:  aluOutput = aluInputB << shiftAmount;
			mipsPkg::aluSrl:  aluOutput = aluInputB >> shiftAmount;
			mipsPkg::aluSra:  aluOutput = $signed(aluInputB) >>> shiftAmount;
			mipsPkg::aluClo, mipsPkg::aluClz: aluOutput = {26'b0, leadingCount};
			default:          aluOutput = '0;
		endcase
	end

	// signed overflow, from operand and result signs
	always_comb begin
		case (aluOperation)
			mipsPkg::aluAdd: aluOverFlow = (aluInputA[31] == aluInputB[31]) &&
				(aluOutput[31] != aluInputA[31]);
			mipsPkg::aluSub: aluOverFlow = (aluInputA[31] != aluInputB[31]) &&
				(aluOutput[31] != aluInputA[31]);
			default:         aluOverFlow = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// ==== source/ResultStage.sv ====
`default_nettype none

module ResultStage (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   issueValid,
	input  mipsPkg::aluDecodeT     decode,
	input  mipsPkg::regIndexT      destReg,
	input  mipsPkg::wordT          aluOutput,
	input  logic                   aluOverFlow,
	output logic                   resultValid,
	output mipsPkg::executeResultT execResult
);

	logic trapTaken;

	assign trapTaken = decode.trapOnOverflow && aluOverFlow;

	// valid and flags
	always_ff @(posedge clk) begin
		if (rst) begin
			resultValid             <= 1'b0;
			execResult.regWrite     <= 1'b0;
			execResult.overflowTrap <= 1'b0;
			execResult.illegal      <= 1'b0;
		end else begin
			resultValid <= issueValid; // one-cycle pulse per issue
			if (issueValid) begin
				execResult.regWrite     <= decode.legal && !trapTaken;
				execResult.overflowTrap <= decode.legal && trapTaken;
				execResult.illegal      <= !decode.legal;
			end
		end
	end

	// payload holds between issues
	always_ff @(posedge clk) begin
		if (issueValid) begin
			execResult.result  <= decode.legal ? aluOutput : '0;
			execResult.destReg <= destReg;
		end
	end

endmodule

`default_nettype wire

// ==== source/ExecuteUnit.sv ====
`default_nettype none

module ExecuteUnit (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    issueValid,
	input  mipsPkg::executeRequestT request,
	output logic                    resultValid,
	output mipsPkg::executeResultT  execResult
);

	mipsPkg::aluDecodeT decode;
	mipsPkg::wordT      aluInputA;
	mipsPkg::wordT      aluInputB;
	mipsPkg::wordT      aluOutput;
	logic               aluOverFlow;

	AluControl aluControl (
		.opcode (request.opcode),
		.funct  (request.funct),
		.decode (decode)
	);

	OperandSelect operandSelect (
		.request   (request),
		.decode    (decode),
		.aluInputA (aluInputA),
		.aluInputB (aluInputB)
	);

	ArithmeticLogicalUnit alu (
		.aluInputA    (aluInputA),
		.aluInputB    (aluInputB),
		.aluOperation (decode.aluOperation),
		.aluOutput    (aluOutput),
		.aluOverFlow  (aluOverFlow)
	);

	// only registered stage, one cycle latency
	ResultStage resultStage (
		.clk         (clk),
		.rst         (rst),
		.issueValid  (issueValid),
		.decode      (decode),
		.destReg     (request.destReg),
		.aluOutput   (aluOutput),
		.aluOverFlow (aluOverFlow),
		.resultValid (resultValid),
		.execResult  (execResult)
	);

endmodule

`default_nettype wire

// ==== testbench/AluModel.svh ====
`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

// run of equal bits from the msb
function automatic int leadingRun(input mipsPkg::wordT word, input logic bitValue);
	int n;
	n = 0;
	while (n < 32 && word[31 - n] == bitValue)
		n++;
	return n;
endfunction

function automatic logic signedOverflow(input longint value);
	return value > 64'sd2147483647 || value < -64'sd2147483648;
endfunction

function automatic mipsPkg::executeResultT computeExpected(input mipsPkg::executeRequestT req);
	mipsPkg::executeResultT res;
	mipsPkg::wordT rs;
	mipsPkg::wordT rt;
	mipsPkg::wordT signImm;
	mipsPkg::wordT zeroImm;
	longint a;
	longint b;
	logic legal;
	logic trapping;
	logic overflow;
	res = '0;
	rs = req.rsValue;
	rt = req.rtValue;
	signImm = {{16{req.immediate[15]}}, req.immediate};
	zeroImm = {16'h0, req.immediate};
	a = longint'($signed(rs)); // exact signed math
	b = longint'($signed(req.opcode == mipsPkg::opSpecial ? rt : signImm));
	legal = 1'b1;
	trapping = 1'b0;
	overflow = 1'b0;
	case (req.opcode)
		mipsPkg::opSpecial: begin
			case (req.funct)
				mipsPkg::fnAnd:  res.result = rs & rt;
				mipsPkg::fnOr:   res.result = rs | rt;
				mipsPkg::fnNor:  res.result = ~(rs | rt);
				mipsPkg::fnXor:  res.result = rs ^ rt;
				mipsPkg::fnSlt:  res.result = (a < b) ? 32'd1 : 32'd0;
				mipsPkg::fnSltu: res.result = (rs < rt) ? 32'd1 : 32'd0;
				mipsPkg::fnAddu: res.result = rs + rt;
				mipsPkg::fnSubu: res.result = rs - rt;
				mipsPkg::fnSll:  res.result = rt << req.shamt;
				mipsPkg::fnSrl:  res.result = rt >> req.shamt;
				mipsPkg::fnSra:  res.result = $signed(rt) >>> req.shamt;
				mipsPkg::fnSllv: res.result = rt << rs[4:0]; // low 5 bits only
				mipsPkg::fnSrlv: res.result = rt >> rs[4:0];
				mipsPkg::fnSrav: res.result = $signed(rt) >>> rs[4:0];
				mipsPkg::fnAdd: begin
					res.result = rs + rt;
					trapping = 1'b1;
					overflow = signedOverflow(a + b);
				end
				mipsPkg::fnSub: begin
					res.result = rs - rt;
					trapping = 1'b1;
					overflow = signedOverflow(a - b);
				end
				default: legal = 1'b0;
			endcase
		end
		mipsPkg::opSpecial2: begin
			case (req.funct)
				mipsPkg::fnClz: res.result = leadingRun(rs, 1'b0);
				mipsPkg::fnClo: res.result = leadingRun(rs, 1'b1);
				default:        legal = 1'b0;
			endcase
		end
		mipsPkg::opAddi: begin
			res.result = rs + signImm;
			trapping = 1'b1;
			overflow = signedOverflow(a + b);
		end
		mipsPkg::opAddiu: res.result = rs + signImm;
		mipsPkg::opSlti:  res.result = (a < b) ? 32'd1 : 32'd0;
		mipsPkg::opSltiu: res.result = (rs < signImm) ? 32'd1 : 32'd0;
		mipsPkg::opAndi:  res.result = rs & zeroImm;
		mipsPkg::opOri:   res.result = rs | zeroImm;
		mipsPkg::opXori:  res.result = rs ^ zeroImm;
		mipsPkg::opLui:   res.result = {req.immediate, 16'h0};
		default:          legal = 1'b0;
	endcase
	res.destReg = req.destReg;
	res.illegal = !legal;
	res.regWrite = legal && !(trapping && overflow);
	res.overflowTrap = legal && trapping && overflow;
	if (!legal)
		res.result = '0;
	return res;
endfunction

`endif

// ==== testbench/ExecuteUnitTb.sv ====
`default_nettype none

module ExecuteUnitTb;

	localparam int clockPeriod = 40;
	localparam int randomCount = 40;
	// issues over all groups plus room for idle gaps, drains and resets
	localparam int plannedIssues = 90 + 6 * randomCount;
	localparam int idleBudget = 6 * randomCount + 40;

	// supported encodings grouped as logic 0-10, arith 11-16, shift 17-23, count 24-25
	localparam logic [11:0] encodings [26] = '{
		{mipsPkg::opSpecial, mipsPkg::fnAnd}, {mipsPkg::opSpecial, mipsPkg::fnOr},
		{mipsPkg::opSpecial, mipsPkg::fnNor}, {mipsPkg::opSpecial, mipsPkg::fnXor},
		{mipsPkg::opSpecial, mipsPkg::fnSlt}, {mipsPkg::opSpecial, mipsPkg::fnSltu},
		{mipsPkg::opAndi, 6'h11}, {mipsPkg::opOri, 6'h2A}, {mipsPkg::opXori, 6'h05},
		{mipsPkg::opSlti, 6'h3C}, {mipsPkg::opSltiu, 6'h20},
		{mipsPkg::opSpecial, mipsPkg::fnAdd}, {mipsPkg::opSpecial, mipsPkg::fnAddu},
		{mipsPkg::opSpecial, mipsPkg::fnSub}, {mipsPkg::opSpecial, mipsPkg::fnSubu},
		{mipsPkg::opAddi, 6'h22}, {mipsPkg::opAddiu, 6'h07},
		{mipsPkg::opSpecial, mipsPkg::fnSll}, {mipsPkg::opSpecial, mipsPkg::fnSrl},
		{mipsPkg::opSpecial, mipsPkg::fnSra}, {mipsPkg::opSpecial, mipsPkg::fnSllv},
		{mipsPkg::opSpecial, mipsPkg::fnSrlv}, {mipsPkg::opSpecial, mipsPkg::fnSrav},
		{mipsPkg::opLui, 6'h00},
		{mipsPkg::opSpecial2, mipsPkg::fnClz}, {mipsPkg::opSpecial2, mipsPkg::fnClo}
	};

	typedef struct packed {
		mipsPkg::executeResultT expected;
		int                     due;
	} pendingT;

	logic clk = 1'b0;
	logic rst;
	logic issueValid;
	mipsPkg::executeRequestT request;
	logic resultValid;
	mipsPkg::executeResultT execResult;
	pendingT pending[$];
	string pendingNames[$];
	int cycleCount = 0;
	int errorCount = 0;
	integer seed = 36;

	`include "AluModel.svh"

	ExecuteUnit DUT (
		.clk         (clk),
		.rst         (rst),
		.issueValid  (issueValid),
		.request     (request),
		.resultValid (resultValid),
		.execResult  (execResult)
	);

	always #(clockPeriod / 2) clk = ~clk;

	always @(posedge clk) cycleCount <= cycleCount + 1;

	task automatic issueOp(input mipsPkg::opcodeT opcode, input mipsPkg::functT funct,
		input mipsPkg::wordT rs, input mipsPkg::wordT rt, input mipsPkg::shamtT shamt,
		input mipsPkg::immT imm, input string name);
		pendingT entry;
		@(negedge clk);
		request = '{opcode, funct, shamt, rs, rt, imm, 5'($random(seed))};
		issueValid = 1'b1;
		entry.expected = computeExpected(request);
		entry.due = cycleCount + 1; // visible after the next rising edge
		pending.push_back(entry);
		pendingNames.push_back(name);
	endtask

	task automatic issueR(input mipsPkg::functT funct, input mipsPkg::wordT rs,
		input mipsPkg::wordT rt, input mipsPkg::shamtT shamt, input string name);
		issueOp(mipsPkg::opSpecial, funct, rs, rt, shamt, 16'($random(seed)), name);
	endtask

	task automatic issueRandom(input int first, input int last, input string name);
		int index;
		index = first + int'($unsigned($random(seed)) % (last - first + 1));
		issueOp(encodings[index][11:6], encodings[index][5:0], $random(seed),
			$random(seed), 5'($random(seed)), 16'($random(seed)), name);
	endtask

	task automatic idle(input int cycles);
		repeat (cycles) begin
			@(negedge clk);
			issueValid = 1'b0;
		end
	endtask

	task automatic drain();
		idle(1);
		while (pending.size() != 0)
			@(negedge clk);
	endtask

	task automatic checkField(input string testName, input string fieldName,
		input logic [31:0] expected, input logic [31:0] actual);
		assert (actual == expected) else begin
			$display("[ERROR] %s: %s expected 0x%h actual 0x%h", testName, fieldName,
				expected, actual);
			errorCount++;
		end
	endtask

	task automatic checkResetState(input string name);
		checkField(name, "resultValid", 32'd0, 32'(resultValid));
		checkField(name, "regWrite", 32'd0, 32'(execResult.regWrite));
		checkField(name, "overflowTrap", 32'd0, 32'(execResult.overflowTrap));
		checkField(name, "illegal", 32'd0, 32'(execResult.illegal));
	endtask

	// outputs are stable at the falling edge
	always @(negedge clk) begin
		pendingT head;
		string name;
		logic missing;
		logic unexpected;
		missing = pending.size() != 0 && pending[0].due < cycleCount;
		assert (!missing) else begin
			$display("No resultValid for %s, expected in cycle %0d", pendingNames[0],
				pending[0].due);
			errorCount++;
		end
		if (missing) begin
			pending.delete(0);
			pendingNames.delete(0);
		end
		unexpected = resultValid && (pending.size() == 0 || pending[0].due != cycleCount);
		assert (!unexpected) else begin
			$display("resultValid high in cycle %0d with no request issued for it", cycleCount);
			errorCount++;
		end
		if (resultValid && !unexpected) begin
			head = pending.pop_front();
			name = pendingNames.pop_front();
			checkField(name, "result", head.expected.result, execResult.result);
			checkField(name, "destReg", 32'(head.expected.destReg), 32'(execResult.destReg));
			checkField(name, "regWrite", 32'(head.expected.regWrite),
				32'(execResult.regWrite));
			checkField(name, "overflowTrap", 32'(head.expected.overflowTrap),
				32'(execResult.overflowTrap));
			checkField(name, "illegal", 32'(head.expected.illegal), 32'(execResult.illegal));
		end
	end

	initial begin
		rst = 1'b1;
		issueValid = 1'b0;
		request = '0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		checkResetState("initial reset");

		issueR(mipsPkg::fnSlt, 32'hFFFFFFFF, 32'd1, 5'd0, "slt negative");
		issueR(mipsPkg::fnSltu, 32'hFFFFFFFF, 32'd1, 5'd0, "sltu negative");
		issueOp(mipsPkg::opSltiu, 6'd0, 32'd5, 32'd0, 5'd0, 16'hFFFF, "sltiu wrapped imm");
		for (int i = 0; i < randomCount; i++)
			issueRandom(0, 10, $sformatf("logic %0d", i));
		drain();

		issueR(mipsPkg::fnAdd, 32'h7FFFFFFF, 32'd1, 5'd0, "add overflow");
		issueR(mipsPkg::fnAddu, 32'h7FFFFFFF, 32'd1, 5'd0, "addu wrap");
		issueR(mipsPkg::fnSub, 32'h80000000, 32'd1, 5'd0, "sub overflow");
		issueR(mipsPkg::fnSubu, 32'h80000000, 32'd1, 5'd0, "subu wrap");
		issueOp(mipsPkg::opAddi, 6'd0, 32'h7FFFFFFF, 32'd0, 5'd0, 16'd1, "addi overflow");
		issueOp(mipsPkg::opAddi, 6'd0, 32'h80000000, 32'd0, 5'd0, 16'hFFFF, "addi under");
		issueOp(mipsPkg::opAddiu, 6'd0, 32'h7FFFFFFF, 32'd0, 5'd0, 16'd1, "addiu wrap");
		for (int i = 0; i < randomCount; i++)
			issueRandom(11, 16, $sformatf("arith %0d", i));
		drain();

		issueR(mipsPkg::fnSra, 32'd0, 32'h80000010, 5'd4, "sra negative");
		issueR(mipsPkg::fnSll, 32'd0, 32'h00000003, 5'd31, "sll by 31");
		issueR(mipsPkg::fnSrlv, 32'hFFFFFFE3, 32'hF0000000, 5'd0, "srlv low bits");
		issueOp(mipsPkg::opLui, 6'd0, 32'h12345678, 32'd0, 5'd0, 16'hABCD, "lui");
		for (int i = 0; i < randomCount; i++)
			issueRandom(17, 23, $sformatf("shift %0d", i));
		drain();

		issueOp(mipsPkg::opSpecial2, mipsPkg::fnClz, 32'd0, 32'd0, 5'd0, 16'd0, "clz 0");
		issueOp(mipsPkg::opSpecial2, mipsPkg::fnClz, '1, 32'd0, 5'd0, 16'd0, "clz ones");
		issueOp(mipsPkg::opSpecial2, mipsPkg::fnClo, 32'd0, 32'd0, 5'd0, 16'd0, "clo 0");
		issueOp(mipsPkg::opSpecial2, mipsPkg::fnClo, '1, 32'd0, 5'd0, 16'd0, "clo ones");
		for (int k = 0; k < 32; k++) begin
			issueOp(mipsPkg::opSpecial2, mipsPkg::fnClz, 32'd1 << k, 32'd0, 5'd0, 16'd0,
				$sformatf("clz bit %0d", k));
			issueOp(mipsPkg::opSpecial2, mipsPkg::fnClo, ~(32'd1 << k), 32'd0, 5'd0, 16'd0,
				$sformatf("clo bit %0d", k));
		end
		for (int i = 0; i < randomCount; i++)
			issueRandom(24, 25, $sformatf("count %0d", i));
		drain();

		issueOp(6'h02, 6'd0, 32'd1, 32'd2, 5'd0, 16'h1234, "opcode j");
		issueOp(6'h23, 6'd0, 32'd1, 32'd2, 5'd0, 16'h0010, "opcode lw");
		issueR(6'h01, 32'd7, 32'd9, 5'd3, "funct 0x01");
		issueR(6'h18, 32'd7, 32'd9, 5'd0, "funct mult");
		issueOp(mipsPkg::opSpecial2, 6'h02, 32'd7, 32'd9, 5'd0, 16'd0, "special2 mul");
		drain();

		for (int i = 0; i < 2 * randomCount; i++) begin
			issueRandom(0, 25, $sformatf("stream %0d", i));
			if ($random(seed) % 4 == 0)
				idle(1 + $unsigned($random(seed)) % 3); // random gap
		end
		issueR(6'h3F, 32'd1, 32'd1, 5'd0, "illegal before reset"); // leaves illegal set
		drain();

		@(negedge clk);
		rst = 1'b1;
		issueValid = 1'b1; // strobe swallowed by the reset
		@(negedge clk);
		issueValid = 1'b0;
		repeat (2) @(negedge clk);
		rst = 1'b0;
		checkResetState("mid-run reset");
		issueRandom(0, 25, "after reset 0");
		issueRandom(0, 25, "after reset 1");
		drain();

		$display("Checks finished with %0d errors", errorCount);
		if (errorCount == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

	initial begin
		#((plannedIssues + idleBudget + 50) * clockPeriod);
		$display("Timeout: the run did not end within %0d cycles",
			plannedIssues + idleBudget + 50);
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+testbench
source/mipsPkg.sv
source/AluControl.sv
source/OperandSelect.sv
source/LeadingCount.sv
source/ArithmeticLogicalUnit.sv
source/ResultStage.sv
source/ExecuteUnit.sv
testbench/ExecuteUnitTb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --assert -j 0
TOP       = ExecuteUnitTb
FILELIST  = build.f
OBJDIR    = obj_dir
PASSTEXT  = Simulation completed successfully

.PHONY: help test clean

help:
	@echo "make help   list the targets"
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASSTEXT)"

clean:
	rm -rf $(OBJDIR)
